// File: mixer_macros.svh
////////////////////////////////////////////////////////////////////////////
// Two-tone mixing synthesizer constants
// Widths, boxcar length and fixed tone B levels
////////////////////////////////////////////////////////////////////////////
`ifndef MIXER_MACROS_SVH
`define MIXER_MACROS_SVH

`define MIX_PHASE_W     8   // Oscillator phase bits
`define MIX_SAMPLE_W    8   // Signed sine sample bits
`define MIX_DAC_W       8   // Unsigned DAC code bits
`define MIX_INCR_A_W    7
`define MIX_INCR_B_W    6

`define MIX_BOX_TAPS    4   // Boxcar length
`define MIX_BOX_SHIFT   2   // log2 of the boxcar length

`define MIX_DAC_OFFSET  127 // Midscale for the resistor ladder
`define MIX_FULL_AMP    127
`define MIX_HALF_AMP    64

`endif

// File: mixer_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Mixer types package
// Phase, sample, product, DAC code and boxcar sum types
////////////////////////////////////////////////////////////////////////////
`include "mixer_macros.svh"

package mixer_pkg;

    // Phase wraps modulo 2**MIX_PHASE_W
    typedef logic [`MIX_PHASE_W-1:0] phase_t;

    typedef logic signed [`MIX_SAMPLE_W-1:0] sample_t;

    // Full product of two samples
    typedef logic signed [2*`MIX_SAMPLE_W-1:0] product_t;

    typedef logic [`MIX_DAC_W-1:0] dac_t;

    // Holds four full-scale codes without overflow
    typedef logic [`MIX_DAC_W+`MIX_BOX_SHIFT-1:0] box_sum_t;

    // Per-oscillator increments, sized to their pin fields
    typedef logic [`MIX_INCR_A_W-1:0] incr_a_t;
    typedef logic [`MIX_INCR_B_W-1:0] incr_b_t;

endpackage

// File: sine_lookup.sv
////////////////////////////////////////////////////////////////////////////
// Sine lookup
// Quarter-wave table giving a signed full-cycle sine from an 8-bit phase
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sine_lookup (
    input  mixer_pkg::phase_t  phase,
    output mixer_pkg::sample_t sample
);
    import mixer_pkg::*;

    // round(127 * sin(2*pi*k/256)) for k = 0..63
    localparam sample_t quarter_wave [64] = '{
        8'sd0,   8'sd3,   8'sd6,   8'sd9,   8'sd12,  8'sd16,  8'sd19,  8'sd22,
        8'sd25,  8'sd28,  8'sd31,  8'sd34,  8'sd37,  8'sd40,  8'sd43,  8'sd46,
        8'sd49,  8'sd51,  8'sd54,  8'sd57,  8'sd60,  8'sd63,  8'sd65,  8'sd68,
        8'sd71,  8'sd73,  8'sd76,  8'sd78,  8'sd81,  8'sd83,  8'sd85,  8'sd88,
        8'sd90,  8'sd92,  8'sd94,  8'sd96,  8'sd98,  8'sd100, 8'sd102, 8'sd104,
        8'sd106, 8'sd107, 8'sd109, 8'sd111, 8'sd112, 8'sd113, 8'sd115, 8'sd116,
        8'sd117, 8'sd118, 8'sd120, 8'sd121, 8'sd122, 8'sd122, 8'sd123, 8'sd124,
        8'sd125, 8'sd125, 8'sd126, 8'sd126, 8'sd126, 8'sd127, 8'sd127, 8'sd127
    };

    logic [1:0] quadrant;
    logic [5:0] idx;
    logic [5:0] mirror_idx;
    sample_t    magnitude;

    assign quadrant   = phase[7:6];
    assign idx        = phase[5:0];

    // 64 - idx, only used when idx is nonzero
    assign mirror_idx = 6'd0 - idx;

    always_comb begin
        if (quadrant[0]) begin
            // Falling half of each lobe, read the table backwards
            if (idx == 6'd0) begin
                magnitude = 8'sd127; // Peak, one past the table end
            end else begin
                magnitude = quarter_wave[mirror_idx];
            end
        end else begin
            magnitude = quarter_wave[idx];
        end
    end

    // Second half cycle is the negative lobe
    assign sample = quadrant[1] ? -magnitude : magnitude;

endmodule

// File: nco.sv
////////////////////////////////////////////////////////////////////////////
// Numerically controlled oscillator
// Phase accumulator with a sized increment, driving a sine lookup
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module nco #(
    parameter type incr_t = mixer_pkg::incr_a_t
) (
    input  logic               clk,
    input  logic               rst_n,
    input  incr_t              phase_incr,
    output mixer_pkg::sample_t sample
);
    import mixer_pkg::*;

    phase_t phase;
    phase_t step;

    // Increment is narrower than the phase, zero extended
    assign step = phase_t'(phase_incr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + step; // Wraps modulo 256
        end
    end

    // Sample follows the phase with no extra stage
    sine_lookup u_sine_lookup (
        .phase  (phase),
        .sample (sample)
    );

endmodule

// File: tone_mixer.sv
////////////////////////////////////////////////////////////////////////////
// Tone mixer
// Selects tone B level, multiplies the tones, offsets to a DAC code
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mixer_macros.svh"

module tone_mixer (
    input  logic               clk,
    input  logic               rst_n,
    input  mixer_pkg::sample_t sample_a,
    input  mixer_pkg::sample_t sample_b,
    input  logic               bypass_b,
    input  logic               low_amp_b,
    output mixer_pkg::dac_t    mix_code
);
    import mixer_pkg::*;

    sample_t  tone_b_sel;
    sample_t  tone_a_q;
    sample_t  tone_b_q;
    product_t product_q;

    // Tone B source and level
    always_comb begin
        if (bypass_b) begin
            if (low_amp_b) begin
                tone_b_sel = sample_t'(`MIX_HALF_AMP);
            end else begin
                tone_b_sel = sample_t'(`MIX_FULL_AMP);
            end
        end else begin
            if (low_amp_b) begin
                tone_b_sel = sample_b >>> 1; // Keeps the sign of negative samples
            end else begin
                tone_b_sel = sample_b;
            end
        end
    end

    // Three stages from sample in to mix_code
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tone_a_q  <= '0;
            tone_b_q  <= '0;
            product_q <= '0;
            mix_code  <= '0;
        end else begin
            tone_a_q  <= sample_a;
            tone_b_q  <= tone_b_sel;
            product_q <= product_t'(tone_a_q) * product_t'(tone_b_q);

            // Drop the sign bit and low bits, then shift to midscale
            mix_code  <= product_q[14:7] + dac_t'(`MIX_DAC_OFFSET);
        end
    end

endmodule

// File: boxcar_filter.sv
////////////////////////////////////////////////////////////////////////////
// Boxcar filter
// Four-tap running average with a raw/filtered output select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mixer_macros.svh"

module boxcar_filter (
    input  logic            clk,
    input  logic            rst_n,
    input  mixer_pkg::dac_t mix_code,
    input  logic            filter_on,
    output mixer_pkg::dac_t out_code
);
    import mixer_pkg::*;

    dac_t     history [`MIX_BOX_TAPS];
    box_sum_t box_sum;
    dac_t     box_avg;

    // Divide by the tap count
    assign box_avg = dac_t'(box_sum >> `MIX_BOX_SHIFT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            box_sum  <= '0;
            out_code <= '0;
            for (int i = 0; i < `MIX_BOX_TAPS; i++) begin
                history[i] <= '0;
            end
        end else begin
            // New code in, oldest code out
            box_sum <= box_sum + box_sum_t'(mix_code)
                     - box_sum_t'(history[`MIX_BOX_TAPS-1]);

            history[0] <= mix_code;
            for (int i = 1; i < `MIX_BOX_TAPS; i++) begin
                history[i] <= history[i-1];
            end

            out_code <= filter_on ? box_avg : mix_code;
        end
    end

endmodule

// File: nco_mixer_top.sv
////////////////////////////////////////////////////////////////////////////
// Two-tone mixing synthesizer top
// Pin control registers, two oscillators, mixer and boxcar filter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module nco_mixer_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] ui_in,
    input  logic [7:0] uio_in,
    output logic [7:0] uo_out
);
    import mixer_pkg::*;

    logic    filter_on;
    incr_a_t phase_incr_a;
    logic    bypass_b;
    logic    low_amp_b;
    incr_b_t phase_incr_b;

    sample_t sample_a;
    sample_t sample_b;
    dac_t    mix_code;

    // Control levels sampled every cycle
    always_ff @(posedge clk) begin
        filter_on    <= ui_in[7];
        phase_incr_a <= ui_in[6:0];
        bypass_b     <= uio_in[7];
        low_amp_b    <= uio_in[6];
        phase_incr_b <= uio_in[5:0];
    end

    nco #(
        .incr_t (incr_a_t)
    ) u_nco_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_incr (phase_incr_a),
        .sample     (sample_a)
    );

    // Narrower increment, lower top frequency
    nco #(
        .incr_t (incr_b_t)
    ) u_nco_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_incr (phase_incr_b),
        .sample     (sample_b)
    );

    tone_mixer u_tone_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_a  (sample_a),
        .sample_b  (sample_b),
        .bypass_b  (bypass_b),
        .low_amp_b (low_amp_b),
        .mix_code  (mix_code)
    );

    boxcar_filter u_boxcar_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .mix_code  (mix_code),
        .filter_on (filter_on),
        .out_code  (uo_out)     // Straight to the DAC pins
    );

endmodule

// File: tb_nco_mixer.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the two-tone mixing synthesizer
// Random control levels, checked each cycle against a register-level model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_nco_mixer;

    localparam int  clk_period   = 100;
    localparam int  total_cycles = 3 + 1 + 5*200 + 3*200 + 4*200 + 4*100 + 1000;
    localparam int  margin       = 200;
    localparam real pi           = 3.14159265358979;

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;

    integer seed;
    int     test_errors;
    int     test_cycles;
    int     pass_count;
    int     fail_count;

    // Model state, one variable per DUT register
    int m_filter_on;
    int m_incr_a;
    int m_bypass_b;
    int m_low_amp_b;
    int m_incr_b;
    int m_phase_a;
    int m_phase_b;
    int m_tone_a;
    int m_tone_b;
    int m_prod;
    int m_mix;
    int m_out;
    int m_hist [4];

    nco_mixer_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .ui_in  (ui_in),
        .uio_in (uio_in),
        .uo_out (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 127 * sin, rounded to the nearest integer
    function automatic int sine_ref(input int phase);
        real x;
        x = 127.0 * $sin(2.0 * pi * phase / 256.0);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end else begin
            return -$rtoi(0.5 - x);
        end
    endfunction

    function automatic int tone_b_ref(input int bypass, input int low_amp, input int sample);
        if (bypass != 0) begin
            return (low_amp != 0) ? 64 : 127;
        end else if (low_amp != 0) begin
            return sample >>> 1; // Floor of half, also for negative samples
        end else begin
            return sample;
        end
    endfunction

    // One rising edge of the model
    task automatic model_edge();
        if (!rst_n) begin
            m_out     = 0;
            m_mix     = 0;
            m_prod    = 0;
            m_tone_a  = 0;
            m_tone_b  = 0;
            m_phase_a = 0;
            m_phase_b = 0;
            for (int i = 0; i < 4; i++) begin
                m_hist[i] = 0;
            end
        end else begin
            // Later stages first so each one reads the old value of the stage before
            if (m_filter_on != 0) begin
                m_out = (m_hist[0] + m_hist[1] + m_hist[2] + m_hist[3]) >> 2;
            end else begin
                m_out = m_mix;
            end
            for (int i = 3; i > 0; i--) begin
                m_hist[i] = m_hist[i-1];
            end
            m_hist[0] = m_mix;
            m_mix     = (((m_prod >>> 7) & 255) + 127) & 255; // Bits 14:7 plus midscale
            m_prod    = m_tone_a * m_tone_b;
            m_tone_a  = sine_ref(m_phase_a);
            m_tone_b  = tone_b_ref(m_bypass_b, m_low_amp_b, sine_ref(m_phase_b));
            m_phase_a = (m_phase_a + m_incr_a) % 256;
            m_phase_b = (m_phase_b + m_incr_b) % 256;
        end
        // Control registers load on every edge, reset or not
        m_filter_on = int'(ui_in[7]);
        m_incr_a    = int'(ui_in[6:0]);
        m_bypass_b  = int'(uio_in[7]);
        m_low_amp_b = int'(uio_in[6]);
        m_incr_b    = int'(uio_in[5:0]);
    endtask

    task automatic check_out();
        logic [7:0] exp_out;
        exp_out = 8'(m_out);
        if (uo_out !== exp_out) begin
            $display("ERROR uo_out expected 0x%h actual 0x%h at %0t", exp_out, uo_out, $time);
            test_errors++;
        end
    endtask

    // Edge, model update, then compare once the outputs have settled
    task automatic step();
        @(posedge clk);
        model_edge();
        #1;
        check_out();
        test_cycles++;
    endtask

    task automatic hold_controls(input logic [7:0] ui, input logic [7:0] uio, input int cycles);
        ui_in  = ui;
        uio_in = uio;
        repeat (cycles) step();
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: %0d cycles, passed", name, test_cycles);
        end else begin
            fail_count++;
            $display("%s: %0d cycles, %0d mismatches, failed", name, test_cycles, test_errors);
        end
        test_errors = 0;
        test_cycles = 0;
    endtask

    task automatic run_reset_test();
        repeat (3) begin
            step();
            if (uo_out !== 8'h00) begin
                $display("ERROR uo_out expected 0x00 actual 0x%h during reset", uo_out);
                test_errors++;
            end
        end
        rst_n = 1'b1;
        step();
        if (uo_out !== 8'h00) begin
            $display("ERROR uo_out expected 0x00 actual 0x%h after reset release", uo_out);
            test_errors++;
        end
        report_test("reset");
    endtask

    task automatic run_tone_a_test();
        logic [6:0] incr_a;
        logic [5:0] incr_b;
        for (int k = 0; k < 5; k++) begin
            incr_a = 7'($random(seed));
            incr_b = 6'($random(seed));
            hold_controls({1'b0, incr_a}, {2'b10, incr_b}, 200);
        end
        report_test("tone A with full bypass");
    endtask

    task automatic run_low_bypass_test();
        logic [6:0] incr_a;
        logic [5:0] incr_b;
        for (int k = 0; k < 3; k++) begin
            incr_a = 7'($random(seed));
            incr_b = 6'($random(seed));
            hold_controls({1'b0, incr_a}, {2'b11, incr_b}, 200);
        end
        report_test("tone A with half bypass");
    endtask

    task automatic run_two_tone_test();
        logic [6:0] incr_a;
        logic [5:0] incr_b;
        for (int k = 0; k < 4; k++) begin
            incr_a = 7'($random(seed));
            incr_b = 6'($random(seed));
            hold_controls({1'b0, incr_a}, {1'b0, k[0], incr_b}, 200); // Full, then half
        end
        report_test("two live tones");
    endtask

    task automatic run_boxcar_test();
        logic [6:0] incr_a;
        logic [7:0] uio;
        for (int k = 0; k < 4; k++) begin
            incr_a = 7'($random(seed));
            uio    = 8'($random(seed));
            hold_controls({1'b1, incr_a}, uio, 100);
        end
        report_test("boxcar filter");
    endtask

    task automatic run_random_control_test();
        repeat (1000) begin
            ui_in  = 8'($random(seed));
            uio_in = 8'($random(seed));
            step();
        end
        report_test("random control changes");
    endtask

    initial begin
        seed        = 32'hc66a68c2;
        rst_n       = 1'b0;
        ui_in       = 8'h00;
        uio_in      = 8'h00;
        test_errors = 0;
        test_cycles = 0;
        pass_count  = 0;
        fail_count  = 0;

        run_reset_test();
        run_tone_a_test();
        run_low_bypass_test();
        run_two_tone_test();
        run_boxcar_test();
        run_random_control_test();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the cycle count of all tests
    initial begin
        #((total_cycles + margin) * clk_period);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
mixer_pkg.sv
sine_lookup.sv
nco.sv
tone_mixer.sv
boxcar_filter.sv
nco_mixer_top.sv
tb_nco_mixer.sv

// File: Makefile
# Verilator flow for the two-tone mixing synthesizer

TOP := tb_nco_mixer

.PHONY: all lint sim clean

all: sim

# Static checks over the RTL and the testbench
lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

# Build and run, pass only if the testbench prints its pass line
sim:
	verilator --binary --timing --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
